/* verilog.f */
rtl/can_seq_pkg.sv
rtl/can_wait_timer.sv
rtl/can_reg_access.sv
rtl/can_cmd_sequencer.sv
rtl/can_interface_ctrl.sv
verification/can_interface_sva.sv
verification/tb_can_interface.sv

/* Bender.yml */
package:
  name: can_interface_ctrl

sources:
  - rtl/can_seq_pkg.sv
  - rtl/can_wait_timer.sv
  - rtl/can_reg_access.sv
  - rtl/can_cmd_sequencer.sv
  - rtl/can_interface_ctrl.sv
  - target: test
    files:
      - verification/can_interface_sva.sv
      - verification/tb_can_interface.sv

/* verification/tb_can_interface.sv */
// testbench for the CAN sequencer top; default waits, n_buses kept in 0..3, fixed seed
`default_nettype none
`timescale 1ns/10ps

module tb_can_interface;

   localparam int CLK_PERIOD = 100;
   localparam int RST_CYCLES = 8;
   localparam int INIT_WAIT  = 10;
   localparam int READ_WAIT  = 20;
   localparam int N_CMDS     = 16;
   localparam int N_ABORTS   = 4;
   localparam int MAX_GAP    = 6;
   localparam int MAX_SEND   = 12;
   localparam int CMD_BOUND  = 4 * (INIT_WAIT + 7 * 3 + 4) + MAX_SEND;   // init over 4 buses
   localparam int WATCHDOG   = ((N_CMDS + 2 * N_ABORTS) * (CMD_BOUND + MAX_GAP + 4)
                                + RST_CYCLES + 2) * 3 / 2;

   // register lists per command
   localparam can_seq_pkg::can_reg_e INIT_REGS [7] = '{
      can_seq_pkg::REG_PRESCALE, can_seq_pkg::REG_GENERAL, can_seq_pkg::REG_IRQ,
      can_seq_pkg::REG_IDR3, can_seq_pkg::REG_IDR4, can_seq_pkg::REG_ACC_MASK1,
      can_seq_pkg::REG_ACC_MASK2};
   localparam can_seq_pkg::can_reg_e READ_REGS [5] = '{
      can_seq_pkg::REG_IDR3, can_seq_pkg::REG_RB1, can_seq_pkg::REG_RB2,
      can_seq_pkg::REG_RB3, can_seq_pkg::REG_RB4};
   localparam can_seq_pkg::can_reg_e WRITE_REGS [7] = '{
      can_seq_pkg::REG_GENERAL, can_seq_pkg::REG_TX_ID, can_seq_pkg::REG_D1,
      can_seq_pkg::REG_D2, can_seq_pkg::REG_D3, can_seq_pkg::REG_D4, can_seq_pkg::REG_TX_CMD};
   localparam can_seq_pkg::can_reg_e IRQ_REGS [2] = '{
      can_seq_pkg::REG_GENERAL, can_seq_pkg::REG_IRQ};

   logic                          clk = 1'b0;
   logic                          rst;
   logic                          abort;
   can_seq_pkg::host_cmd_t        cmd;
   logic                          send;
   logic [can_seq_pkg::BUS_W-1:0] n_buses;
   logic                          ack;
   can_seq_pkg::can_reg_bus_t     reg_bus;
   logic                          rec_en;
   logic                          start_init;
   logic                          loaded;
   logic [can_seq_pkg::BUS_W-1:0] bus_sel;

   int unsigned           errors = 0;
   logic [31:0]           rng = 32'd30;   // lcg state
   can_seq_pkg::can_reg_e strobe_addr [$];
   logic                  strobe_rec [$];
   int                    init_sel [$];
   int                    init_mark [$];  // strobes seen before each settle pulse

   can_interface_ctrl #(
      .INIT_WAIT (INIT_WAIT),
      .READ_WAIT (READ_WAIT)
   ) dut_i (
      .clk        (clk),
      .rst        (rst),
      .abort      (abort),
      .cmd        (cmd),
      .send       (send),
      .n_buses    (n_buses),
      .ack        (ack),
      .reg_bus    (reg_bus),
      .rec_en     (rec_en),
      .start_init (start_init),
      .loaded     (loaded),
      .bus_sel    (bus_sel)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ----------------------------------------
   // bus monitor
   // ----------------------------------------
   always @(posedge clk) begin
      if (!rst && reg_bus.cs) begin
         strobe_addr.push_back(reg_bus.addr);
         strobe_rec.push_back(rec_en);
      end
      if (!rst && start_init) begin
         init_sel.push_back(int'(bus_sel));
         init_mark.push_back(strobe_addr.size());
      end
   end

   function automatic int unsigned rand_below(int unsigned n);
      rng = rng * 32'd1664525 + 32'd1013904223;
      return (rng >> 16) % n;   // upper bits of the lcg state
   endfunction

   function automatic can_seq_pkg::can_reg_e expected_reg(can_seq_pkg::can_op_e op, int i);
      case (op)
         can_seq_pkg::OP_INIT:  return INIT_REGS[i % 7];
         can_seq_pkg::OP_READ:  return READ_REGS[i];
         can_seq_pkg::OP_WRITE: return WRITE_REGS[i];
         default:               return IRQ_REGS[i];
      endcase
   endfunction

   task automatic check_val(string name, int exp, int act);
      assert (exp == act) else begin
         errors++;
         $display("ERR %s expected %0h actual %0h", name, exp, act);
      end
   endtask

   task automatic check_true(logic cond, string what);
      assert (cond) else begin
         errors++;
         $display("%s", what);
      end
   endtask

   task automatic clear_monitor();
      strobe_addr.delete();
      strobe_rec.delete();
      init_sel.delete();
      init_mark.delete();
   endtask

   // wait for loaded or ack within the worst command length
   task automatic wait_high(bit want_loaded, string name);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!(want_loaded ? loaded : ack) && n < CMD_BOUND);
      check_true(want_loaded ? loaded : ack,
                 {name, " timed out waiting for ", want_loaded ? "loaded" : "ack"});
   endtask

   // ----------------------------------------
   // command runs
   // ----------------------------------------
   task automatic run_cmd(can_seq_pkg::can_op_e op, string name);
      int k;
      int n_exp;
      k = (op == can_seq_pkg::OP_INIT) ? rand_below(4) : 0;
      check_val({name, " idle strobes"}, 0, strobe_addr.size());
      clear_monitor();
      cmd.op  <= op;
      cmd.req <= 1'b1;
      n_buses <= can_seq_pkg::BUS_W'(k);
      if (op == can_seq_pkg::OP_WRITE) begin
         wait_high(1'b1, name);
         check_val({name, " steps before send"}, 6, strobe_addr.size());
         repeat (rand_below(MAX_SEND)) begin
            @(posedge clk);
            check_true(loaded && !reg_bus.cs, {name, " left the send wait too early"});
         end
         send <= 1'b1;
         @(posedge clk);
         send <= 1'b0;
      end
      wait_high(1'b0, name);
      case (op)
         can_seq_pkg::OP_INIT:  n_exp = 7 * (k + 1);
         can_seq_pkg::OP_READ:  n_exp = 5;
         can_seq_pkg::OP_WRITE: n_exp = 7;
         default:               n_exp = 2;
      endcase
      check_val({name, " step count"}, n_exp, strobe_addr.size());
      for (int i = 0; i < strobe_addr.size() && i < n_exp; i++) begin
         check_val($sformatf("%s step %0d addr", name, i), expected_reg(op, i), strobe_addr[i]);
         check_val($sformatf("%s step %0d rec_en", name, i), op == can_seq_pkg::OP_READ,
                   strobe_rec[i]);
      end
      check_val({name, " settle pulses"}, (op == can_seq_pkg::OP_INIT) ? k + 1 : 0,
                init_sel.size());
      for (int b = 0; b < init_sel.size(); b++) begin
         check_val($sformatf("%s bus_sel %0d", name, b), b, init_sel[b]);
         check_val($sformatf("%s pulse %0d position", name, b), 7 * b, init_mark[b]);
      end
      clear_monitor();   // bus stays idle until the next req
      cmd.req <= 1'b0;
      repeat (2) @(posedge clk);   // ack low one cycle after req low
      check_val({name, " ack after req drop"}, 0, ack);
   endtask

   task automatic abort_cmd(can_seq_pkg::can_op_e op);
      clear_monitor();
      cmd.op  <= op;
      cmd.req <= 1'b1;
      n_buses <= can_seq_pkg::BUS_W'(rand_below(4));
      repeat (1 + rand_below(30)) @(posedge clk);
      abort   <= 1'b1;
      cmd.req <= 1'b0;
      @(posedge clk);
      abort <= 1'b0;
      @(posedge clk);
      check_true(!reg_bus.cs && reg_bus.wr_n && reg_bus.rd_n && !ack,
                 "bus or ack still active after abort");
      clear_monitor();   // partial list dropped
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      can_seq_pkg::can_op_e op;
      int unsigned          first;
      rst     = 1'b1;
      abort   = 1'b0;
      cmd     = '0;
      send    = 1'b0;
      n_buses = '0;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      first = rand_below(4);
      for (int i = 0; i < N_CMDS; i++) begin
         // all four opcodes first and then any order
         op = can_seq_pkg::can_op_e'(2'((i < 4) ? (first + i) % 4 : rand_below(4)));
         run_cmd(op, $sformatf("cmd%0d_%s", i, op.name()));
         repeat (rand_below(MAX_GAP + 1)) @(posedge clk);
      end
      for (int i = 0; i < N_ABORTS; i++) begin
         abort_cmd(can_seq_pkg::can_op_e'(2'(i)));
         op = can_seq_pkg::can_op_e'(2'(rand_below(4)));
         run_cmd(op, $sformatf("after_abort%0d_%s", i, op.name()));
      end
      $display("error count: checks %0d, assertions %0d", errors, dut_i.sva_i.fail_cnt);
      if (errors == 0 && dut_i.sva_i.fail_cnt == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("watchdog expired before the command sequence finished");
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verification/can_interface_sva.sv */
// bus and handshake protocol checks, bound into the top; assumes a single clock domain
`default_nettype none
`timescale 1ns/10ps

module can_interface_sva (
   input wire logic                      clk,
   input wire logic                      rst,
   input wire logic                      abort,
   input wire can_seq_pkg::host_cmd_t    cmd,
   input wire logic                      ack,
   input wire can_seq_pkg::can_reg_bus_t reg_bus,
   input wire logic                      rec_en
);

   int unsigned fail_cnt = 0;   // failed assertions so far

   // ----------------------------------------
   // register bus
   // ----------------------------------------
   // strobe only after a setup cycle on the same address
   a_setup_before_cs: assert property (@(posedge clk) disable iff (rst)
      reg_bus.cs |-> !$past(reg_bus.cs) && $past(reg_bus.addr) == reg_bus.addr &&
                     !$past(reg_bus.wr_n && reg_bus.rd_n))
      else begin
         fail_cnt++;
         $error("cs high without a setup cycle on the same address");
      end

   a_one_direction: assert property (@(posedge clk) disable iff (rst)
      !(!reg_bus.wr_n && !reg_bus.rd_n))
      else begin
         fail_cnt++;
         $error("wr_n and rd_n low together");
      end

   a_rec_en_on_read: assert property (@(posedge clk) disable iff (rst)
      rec_en |-> reg_bus.cs && !reg_bus.rd_n)
      else begin
         fail_cnt++;
         $error("rec_en outside a read strobe");
      end

   // ----------------------------------------
   // handshake
   // ----------------------------------------
   a_ack_holds: assert property (@(posedge clk) disable iff (rst)
      (ack && cmd.req && !abort) |=> ack)
      else begin
         fail_cnt++;
         $error("ack fell while req was still high");
      end

endmodule

bind can_interface_ctrl can_interface_sva sva_i (
   .clk     (clk),
   .rst     (rst),
   .abort   (abort),
   .cmd     (cmd),
   .ack     (ack),
   .reg_bus (reg_bus),
   .rec_en  (rec_en)
);

`default_nettype wire

/* rtl/can_interface_ctrl.sv */
// CAN bridge sequencer top; abort merges bridge timeout, register data is not carried
`default_nettype none
`timescale 1ns/10ps

module can_interface_ctrl #(
   parameter int INIT_WAIT = 10,   // settle cycles per bus
   parameter int READ_WAIT = 20    // frame settle before a read
) (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          abort,
   input  wire can_seq_pkg::host_cmd_t        cmd,
   input  wire logic                          send,
   input  wire logic [can_seq_pkg::BUS_W-1:0] n_buses,
   output wire logic                          ack,
   output wire can_seq_pkg::can_reg_bus_t     reg_bus,
   output wire logic                          rec_en,
   output wire logic                          start_init,
   output wire logic                          loaded,
   output wire logic [can_seq_pkg::BUS_W-1:0] bus_sel
);

   can_seq_pkg::reg_step_t step;        // sequencer to bus phases
   logic                   step_done;

   can_cmd_sequencer #(
      .INIT_WAIT (INIT_WAIT),
      .READ_WAIT (READ_WAIT)
   ) seq_i (
      .clk        (clk),
      .rst        (rst),
      .abort      (abort),
      .cmd        (cmd),
      .send       (send),
      .n_buses    (n_buses),
      .step_done  (step_done),
      .ack        (ack),
      .step       (step),
      .start_init (start_init),
      .loaded     (loaded),
      .bus_sel    (bus_sel)
   );

   can_reg_access acc_i (
      .clk       (clk),
      .rst       (rst),
      .abort     (abort),
      .step      (step),
      .step_done (step_done),
      .reg_bus   (reg_bus),
      .rec_en    (rec_en)
   );

endmodule

`default_nettype wire

/* rtl/can_cmd_sequencer.sv */
// command FSM; n_buses must stay stable during init, one command at a time via req/ack
`default_nettype none
`timescale 1ns/10ps

module can_cmd_sequencer #(
   parameter int INIT_WAIT = 10,
   parameter int READ_WAIT = 20
) (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic                          abort,
   input  wire can_seq_pkg::host_cmd_t        cmd,
   input  wire logic                          send,
   input  wire logic [can_seq_pkg::BUS_W-1:0] n_buses,
   input  wire logic                          step_done,
   output logic                               ack,
   output can_seq_pkg::reg_step_t             step,
   output logic                               start_init,
   output logic                               loaded,
   output logic [can_seq_pkg::BUS_W-1:0]      bus_sel
);

   localparam int MAX_WAIT = (INIT_WAIT > READ_WAIT) ? INIT_WAIT : READ_WAIT;
   localparam int CNT_W    = $clog2(MAX_WAIT + 1);

   // register lists, row per opcode, padded with the idle address
   localparam can_seq_pkg::can_reg_e STEP_LIST [4][8] = '{
      '{can_seq_pkg::REG_PRESCALE, can_seq_pkg::REG_GENERAL, can_seq_pkg::REG_IRQ,
        can_seq_pkg::REG_IDR3, can_seq_pkg::REG_IDR4, can_seq_pkg::REG_ACC_MASK1,
        can_seq_pkg::REG_ACC_MASK2, can_seq_pkg::REG_NONE},
      '{can_seq_pkg::REG_IDR3, can_seq_pkg::REG_RB1, can_seq_pkg::REG_RB2,
        can_seq_pkg::REG_RB3, can_seq_pkg::REG_RB4, can_seq_pkg::REG_NONE,
        can_seq_pkg::REG_NONE, can_seq_pkg::REG_NONE},
      '{can_seq_pkg::REG_GENERAL, can_seq_pkg::REG_TX_ID, can_seq_pkg::REG_D1,
        can_seq_pkg::REG_D2, can_seq_pkg::REG_D3, can_seq_pkg::REG_D4,
        can_seq_pkg::REG_TX_CMD, can_seq_pkg::REG_NONE},
      '{can_seq_pkg::REG_GENERAL, can_seq_pkg::REG_IRQ, can_seq_pkg::REG_NONE,
        can_seq_pkg::REG_NONE, can_seq_pkg::REG_NONE, can_seq_pkg::REG_NONE,
        can_seq_pkg::REG_NONE, can_seq_pkg::REG_NONE}
   };

   can_seq_pkg::seq_state_e       state_q;
   can_seq_pkg::seq_state_e       state_d;
   can_seq_pkg::can_op_e          op_q;
   can_seq_pkg::step_idx_t        idx_q;
   logic [can_seq_pkg::BUS_W-1:0] bus_q;      // bus being initialised
   logic                          tmr_load;
   logic [CNT_W-1:0]              tmr_val;
   logic                          tmr_expired;
   logic                          settle_init;
   logic                          last_step;

   can_wait_timer #(
      .CNT_W (CNT_W)
   ) tmr_i (
      .clk      (clk),
      .rst      (rst),
      .abort    (abort),
      .load     (tmr_load),
      .load_val (tmr_val),
      .expired  (tmr_expired)
   );

   // write has two phases, both end on a last step
   always_comb begin
      unique case (op_q)
         can_seq_pkg::OP_INIT:  last_step = (idx_q == can_seq_pkg::LAST_INIT);
         can_seq_pkg::OP_READ:  last_step = (idx_q == can_seq_pkg::LAST_READ);
         can_seq_pkg::OP_WRITE: last_step = (idx_q >= can_seq_pkg::LAST_WRITE);
         default:               last_step = (idx_q == can_seq_pkg::LAST_IRQ);
      endcase
   end

   // ----------------------------------------
   // next state
   // ----------------------------------------
   always_comb begin
      state_d     = state_q;
      tmr_load    = 1'b0;
      tmr_val     = CNT_W'(INIT_WAIT);
      settle_init = 1'b0;
      unique case (state_q)
         can_seq_pkg::S_IDLE: begin
            if (cmd.req) begin
               if (cmd.op == can_seq_pkg::OP_INIT) begin
                  state_d     = can_seq_pkg::S_SETTLE;
                  tmr_load    = 1'b1;
                  settle_init = 1'b1;
               end else if (cmd.op == can_seq_pkg::OP_READ) begin
                  state_d  = can_seq_pkg::S_SETTLE;   // frame bits settle first
                  tmr_load = 1'b1;
                  tmr_val  = CNT_W'(READ_WAIT);
               end else begin
                  state_d = can_seq_pkg::S_STEPS;
               end
            end
         end
         can_seq_pkg::S_SETTLE: begin
            if (tmr_expired) begin
               state_d = can_seq_pkg::S_STEPS;
            end
         end
         can_seq_pkg::S_STEPS: begin
            if (step_done && last_step) begin
               if (op_q == can_seq_pkg::OP_INIT) begin
                  state_d = can_seq_pkg::S_NEXT_BUS;
               end else if (op_q == can_seq_pkg::OP_WRITE &&
                            idx_q == can_seq_pkg::LAST_WRITE) begin
                  state_d = can_seq_pkg::S_WAIT_SEND;
               end else begin
                  state_d = can_seq_pkg::S_DONE;
               end
            end
         end
         can_seq_pkg::S_WAIT_SEND: begin
            if (send) begin
               state_d = can_seq_pkg::S_STEPS;   // tx_cmd
            end
         end
         can_seq_pkg::S_NEXT_BUS: begin
            if (bus_q == n_buses) begin
               state_d = can_seq_pkg::S_DONE;
            end else begin
               state_d     = can_seq_pkg::S_SETTLE;
               tmr_load    = 1'b1;
               settle_init = 1'b1;
            end
         end
         can_seq_pkg::S_DONE: begin
            if (!cmd.req) begin
               state_d = can_seq_pkg::S_IDLE;
            end
         end
         default: state_d = can_seq_pkg::S_IDLE;
      endcase
   end

   // ----------------------------------------
   // registers
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst || abort) begin
         state_q    <= can_seq_pkg::S_IDLE;
         op_q       <= can_seq_pkg::OP_INIT;
         idx_q      <= '0;
         bus_q      <= '0;
         start_init <= 1'b0;
      end else begin
         state_q    <= state_d;
         start_init <= settle_init;   // first cycle of each bus settle
         if (state_q == can_seq_pkg::S_IDLE && cmd.req) begin
            op_q <= cmd.op;
         end
         if (state_q == can_seq_pkg::S_IDLE || state_q == can_seq_pkg::S_NEXT_BUS) begin
            idx_q <= '0;
         end else if (step_done) begin
            idx_q <= idx_q + 1'b1;
         end
         if (state_q == can_seq_pkg::S_NEXT_BUS) begin
            bus_q <= (bus_q == n_buses) ? '0 : bus_q + 1'b1;
         end
      end
   end

   always_comb begin
      step.valid   = (state_q == can_seq_pkg::S_STEPS);
      step.is_read = (op_q == can_seq_pkg::OP_READ);
      step.addr    = STEP_LIST[op_q][idx_q];
   end

   assign ack     = (state_q == can_seq_pkg::S_DONE);      // held until req drops
   assign loaded  = (state_q == can_seq_pkg::S_WAIT_SEND);
   assign bus_sel = bus_q;

endmodule

`default_nettype wire

/* rtl/can_reg_access.sv */
// one register access per step: setup then strobe, then an idle cycle; no data path
`default_nettype none
`timescale 1ns/10ps

module can_reg_access (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    abort,
   input  wire can_seq_pkg::reg_step_t  step,
   output logic                         step_done,
   output can_seq_pkg::can_reg_bus_t    reg_bus,
   output logic                         rec_en
);

   typedef enum logic [1:0] {
      PH_IDLE,
      PH_SETUP,     // addr and wr_n/rd_n out, cs low
      PH_STROBE     // cs high
   } phase_e;

   phase_e                phase_q;
   can_seq_pkg::can_reg_e addr_q;
   logic                  is_read_q;
   logic                  active;

   // ----------------------------------------
   // phase machine
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst || abort) begin
         phase_q <= PH_IDLE;
      end else begin
         unique case (phase_q)
            PH_IDLE: begin
               if (step.valid) begin
                  phase_q <= PH_SETUP;
               end
            end
            PH_SETUP:  phase_q <= PH_STROBE;
            PH_STROBE: phase_q <= PH_IDLE;   // always one idle cycle after
            default:   phase_q <= PH_IDLE;
         endcase
      end
   end

   // capture the step so addr holds over both cycles
   always_ff @(posedge clk) begin
      if (phase_q == PH_IDLE && step.valid) begin
         addr_q    <= step.addr;
         is_read_q <= step.is_read;
      end
   end

   // ----------------------------------------
   // bus decode
   // ----------------------------------------
   assign active = (phase_q != PH_IDLE);

   always_comb begin
      reg_bus.cs   = (phase_q == PH_STROBE);
      reg_bus.wr_n = ~(active & ~is_read_q);
      reg_bus.rd_n = ~(active & is_read_q);
      reg_bus.addr = active ? addr_q : can_seq_pkg::REG_NONE;
   end

   assign step_done = (phase_q == PH_STROBE);
   assign rec_en    = (phase_q == PH_STROBE) & is_read_q;   // receive buffer strobe

endmodule

`default_nettype wire

/* rtl/can_wait_timer.sv */
// settle wait counter; a load_val of 0 behaves like 1, count must fit in CNT_W bits
`default_nettype none
`timescale 1ns/10ps

module can_wait_timer #(
   parameter int CNT_W = 6
) (
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire logic             abort,
   input  wire logic             load,
   input  wire logic [CNT_W-1:0] load_val,
   output logic                  expired
);

   logic [CNT_W-1:0] cnt_q;   // cycles left

   always_ff @(posedge clk) begin
      if (rst || abort) begin
         cnt_q <= '0;   // parked in the expired state
      end else if (load) begin
         // minus one, the load edge itself counts as a cycle
         cnt_q <= (load_val == '0) ? '0 : load_val - 1'b1;
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // stays high at zero until reloaded
   assign expired = (cnt_q == '0);

endmodule

`default_nettype wire

/* rtl/can_seq_pkg.sv */
// shared types for the CAN command sequencer; register addresses are fixed to a 5 bit map
`default_nettype none

package can_seq_pkg;

   // ----------------------------------------
   // widths
   // ----------------------------------------
   localparam int BUS_W  = 5;   // bus index and n_buses
   localparam int STEP_W = 3;   // step index, longest list is 7

   typedef logic [STEP_W-1:0] step_idx_t;

   // index of the last step in each list
   localparam step_idx_t LAST_INIT  = 3'd6;
   localparam step_idx_t LAST_READ  = 3'd4;
   localparam step_idx_t LAST_WRITE = 3'd5;   // d4, tx_cmd follows after send
   localparam step_idx_t LAST_IRQ   = 3'd1;

   // ----------------------------------------
   // commands and registers
   // ----------------------------------------
   typedef enum logic [1:0] {
      OP_INIT    = 2'd0,
      OP_READ    = 2'd1,
      OP_WRITE   = 2'd2,
      OP_IRQ_CLR = 2'd3
   } can_op_e;

   // controller register map
   typedef enum logic [4:0] {
      REG_RB4       = 5'h00,
      REG_RB3       = 5'h01,
      REG_RB2       = 5'h02,
      REG_RB1       = 5'h03,
      REG_IDR4      = 5'h04,
      REG_IDR3      = 5'h05,
      REG_D4        = 5'h07,
      REG_D3        = 5'h08,
      REG_D2        = 5'h09,
      REG_D1        = 5'h0A,
      REG_TX_ID     = 5'h0C,
      REG_TX_CMD    = 5'h0D,
      REG_GENERAL   = 5'h0E,
      REG_PRESCALE  = 5'h0F,
      REG_ACC_MASK2 = 5'h10,
      REG_ACC_MASK1 = 5'h11,
      REG_IRQ       = 5'h12,
      REG_NONE      = 5'h1F    // bus parked here when idle
   } can_reg_e;

   // ----------------------------------------
   // structs
   // ----------------------------------------
   typedef struct packed {
      logic    req;
      can_op_e op;
   } host_cmd_t;

   typedef struct packed {
      logic     valid;
      logic     is_read;
      can_reg_e addr;
   } reg_step_t;

   typedef struct packed {
      logic     cs;     // high in strobe cycle only
      logic     wr_n;
      logic     rd_n;
      can_reg_e addr;
   } can_reg_bus_t;

   typedef enum logic [2:0] {
      S_IDLE,
      S_SETTLE,
      S_STEPS,
      S_WAIT_SEND,
      S_NEXT_BUS,
      S_DONE
   } seq_state_e;

endpackage

`default_nettype wire
